//--- src/core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// First fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

// Data memory depth in words, a power of two
`define CORE_DMEM_WORDS 256

// ECALL, treated as halt
`define CORE_HALT_INSN 32'h0000_0073

`endif

//--- src/core_pkg.sv
package core_pkg;

    // Data and address word
    typedef logic [31:0] word_t;

    // Major opcodes in instr[6:0] that the core understands
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    // ALU functions
    // PASS_B forwards operand b untouched, used by LUI
    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_SLT    = 3'd5,
        ALU_PASS_B = 3'd6
    } alu_op_e;

    // Fetch to execute
    // Valid low marks a bubble or a squashed wrong-path fetch
    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } fetch_ex_t;

    // Execute to memory pipeline register
    typedef struct packed {
        logic       valid;
        // Control bits, all low for an illegal or invalid slot
        logic       reg_write;
        logic       dren;
        logic       dwen;
        logic       halt;
        // Set only on a valid slot
        logic       illegal;
        logic [4:0] rd;
        // ALU result, or the link address pc+4 for JAL
        word_t      alu_out;
        // Store data after forwarding
        word_t      rs2_data;
        word_t      pc;
    } ex_mem_t;

endpackage

//--- src/fetch_stage.sv
`timescale 1ns/1ns
`include "core_cfg.svh"

module fetch_stage (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                redirect,
    input  core_pkg::word_t     redirect_pc,
    input  logic                halt_seen,
    input  core_pkg::word_t     imem_rdata,
    output logic                imem_req,
    output core_pkg::word_t     imem_addr,
    output core_pkg::fetch_ex_t fetch_ex
);
    import core_pkg::*;

    word_t pc;
    word_t req_pc;
    logic  req_valid;
    // Low for the first cycle out of reset
    logic  started;

    // One request per cycle until a halt has retired
    assign imem_req  = started && !halt_seen;
    assign imem_addr = pc;

    // Response pairs with the address it was requested for
    assign fetch_ex.valid = req_valid;
    assign fetch_ex.pc    = req_pc;
    assign fetch_ex.instr = imem_rdata;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            started   <= 1'b0;
            pc        <= `CORE_RESET_PC;
            req_pc    <= `CORE_RESET_PC;
            req_valid <= 1'b0;
        end else begin
            started <= 1'b1;
            // Request issued during a redirect is on the wrong path
            req_valid <= imem_req && !redirect;
            if (imem_req) begin
                req_pc <= pc;
            end
            // Redirect wins over sequential advance
            if (redirect) begin
                pc <= redirect_pc;
            end else if (imem_req) begin
                pc <= pc + 32'd4;
            end
        end
    end

endmodule

//--- src/execute_stage.sv
`timescale 1ns/1ns
`include "core_cfg.svh"

module execute_stage (
    input  logic                CLK,
    input  logic                nRST,
    input  core_pkg::fetch_ex_t fetch_ex,
    output logic [4:0]          rs1_addr,
    output logic [4:0]          rs2_addr,
    input  core_pkg::word_t     rs1_data,
    input  core_pkg::word_t     rs2_data,
    input  logic                fwd_rs1,
    input  logic                fwd_rs2,
    input  core_pkg::word_t     fwd_data,
    output logic                redirect,
    output core_pkg::word_t     redirect_pc,
    output core_pkg::ex_mem_t   ex_mem
);
    import core_pkg::*;

    word_t      instr;
    word_t      pc;
    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [4:0] rd;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_j;
    word_t      imm_u;
    // Decoded control
    logic       ctl_reg_write;
    logic       ctl_dren;
    logic       ctl_dwen;
    logic       ctl_halt;
    logic       ctl_branch;
    logic       ctl_jal;
    logic       ctl_use_imm;
    logic       illegal_insn;
    alu_op_e    alu_op;
    word_t      op_imm;
    // Datapath
    word_t      rs1_val;
    word_t      rs2_val;
    word_t      src_b;
    word_t      alu_result;
    logic       branch_taken;
    logic       ctl_ok;

    assign instr  = fetch_ex.instr;
    assign pc     = fetch_ex.pc;
    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];

    // Register file read, addresses straight from the encoding
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    // Sign-extended immediates
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    always_comb begin
        ctl_reg_write = 1'b0;
        ctl_dren      = 1'b0;
        ctl_dwen      = 1'b0;
        ctl_halt      = 1'b0;
        ctl_branch    = 1'b0;
        ctl_jal       = 1'b0;
        ctl_use_imm   = 1'b0;
        illegal_insn  = 1'b0;
        alu_op        = ALU_ADD;
        op_imm        = imm_i;
        case (opcode)
            OPC_OP: begin
                ctl_reg_write = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: alu_op = ALU_ADD;
                    10'b0100000_000: alu_op = ALU_SUB;
                    10'b0000000_111: alu_op = ALU_AND;
                    10'b0000000_110: alu_op = ALU_OR;
                    10'b0000000_100: alu_op = ALU_XOR;
                    10'b0000000_010: alu_op = ALU_SLT;
                    default:         illegal_insn = 1'b1;
                endcase
            end
            OPC_OP_IMM: begin
                // ADDI only
                ctl_reg_write = 1'b1;
                ctl_use_imm   = 1'b1;
                illegal_insn  = (funct3 != 3'b000);
            end
            OPC_LUI: begin
                ctl_reg_write = 1'b1;
                ctl_use_imm   = 1'b1;
                op_imm        = imm_u;
                alu_op        = ALU_PASS_B;
            end
            OPC_LOAD: begin
                // LW, address is rs1 + imm
                ctl_reg_write = 1'b1;
                ctl_dren      = 1'b1;
                ctl_use_imm   = 1'b1;
                illegal_insn  = (funct3 != 3'b010);
            end
            OPC_STORE: begin
                ctl_dwen     = 1'b1;
                ctl_use_imm  = 1'b1;
                op_imm       = imm_s;
                illegal_insn = (funct3 != 3'b010);
            end
            OPC_BRANCH: begin
                // BEQ and BNE
                ctl_branch   = 1'b1;
                illegal_insn = (funct3[2:1] != 2'b00);
            end
            OPC_JAL: begin
                ctl_reg_write = 1'b1;
                ctl_jal       = 1'b1;
            end
            OPC_SYSTEM: begin
                ctl_halt     = (instr == `CORE_HALT_INSN);
                illegal_insn = (instr != `CORE_HALT_INSN);
            end
            default: illegal_insn = 1'b1;
        endcase
    end

    // Newest value from the memory stage overrides the register file
    assign rs1_val = fwd_rs1 ? fwd_data : rs1_data;
    assign rs2_val = fwd_rs2 ? fwd_data : rs2_data;
    assign src_b   = ctl_use_imm ? op_imm : rs2_val;

    always_comb begin
        case (alu_op)
            ALU_ADD:    alu_result = rs1_val + src_b;
            ALU_SUB:    alu_result = rs1_val - src_b;
            ALU_AND:    alu_result = rs1_val & src_b;
            ALU_OR:     alu_result = rs1_val | src_b;
            ALU_XOR:    alu_result = rs1_val ^ src_b;
            ALU_SLT:    alu_result = {31'b0, $signed(rs1_val) < $signed(src_b)};
            default:    alu_result = src_b;
        endcase
    end

    // Only a valid, legal instruction may act
    assign ctl_ok = fetch_ex.valid && !illegal_insn;

    // funct3[0] set means BNE
    assign branch_taken = ctl_branch && (funct3[0] ? (rs1_val != rs2_val)
                                                   : (rs1_val == rs2_val));

    assign redirect    = ctl_ok && (branch_taken || ctl_jal);
    assign redirect_pc = ctl_jal ? (pc + imm_j) : (pc + imm_b);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ex_mem <= '0;
        end else begin
            ex_mem.valid     <= fetch_ex.valid;
            ex_mem.reg_write <= ctl_ok && ctl_reg_write;
            ex_mem.dren      <= ctl_ok && ctl_dren;
            ex_mem.dwen      <= ctl_ok && ctl_dwen;
            ex_mem.halt      <= ctl_ok && ctl_halt;
            ex_mem.illegal   <= fetch_ex.valid && illegal_insn;
            ex_mem.rd        <= rd;
            // JAL links pc+4
            ex_mem.alu_out   <= ctl_jal ? (pc + 32'd4) : alu_result;
            ex_mem.rs2_data  <= rs2_val;
            ex_mem.pc        <= pc;
        end
    end

endmodule

//--- src/reg_file.sv
`timescale 1ns/1ns

module reg_file (
    input  logic            CLK,
    input  logic            nRST,
    input  logic [4:0]      rs1_addr,
    input  logic [4:0]      rs2_addr,
    input  logic [4:0]      rd,
    input  logic            wen,
    input  core_pkg::word_t wdata,
    output core_pkg::word_t rs1_data,
    output core_pkg::word_t rs2_data
);
    import core_pkg::*;

    // x1..x31, x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (rd != 5'd0)) begin
            regs[rd] <= wdata;
        end
    end

    // Combinational reads, x0 hardwired to zero
    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

//--- src/mem_stage.sv
`timescale 1ns/1ns
`include "core_cfg.svh"

module mem_stage (
    input  logic              CLK,
    input  logic              nRST,
    input  core_pkg::ex_mem_t ex_mem,
    output logic              rf_wen,
    output logic [4:0]        rf_rd,
    output core_pkg::word_t   wb_data,
    output logic              retire_valid,
    output core_pkg::word_t   retire_pc,
    output logic              halted,
    output logic              illegal
);
    import core_pkg::*;

    localparam int unsigned DMEM_AW = $clog2(`CORE_DMEM_WORDS);

    word_t               dmem [0:`CORE_DMEM_WORDS-1];
    logic [DMEM_AW-1:0]  word_idx;
    word_t               load_data;
    logic                slot_live;

    // Word index from the byte address, wraps at the array depth
    assign word_idx = ex_mem.alu_out[DMEM_AW+1:2];

    // Slots behind a retired halt are dropped
    assign slot_live = ex_mem.valid && !halted;

    // Combinational read so a load result can be forwarded at once
    assign load_data = dmem[word_idx];

    // Store lands at the end of the cycle
    always_ff @(posedge CLK) begin
        if (slot_live && ex_mem.dwen) begin
            dmem[word_idx] <= ex_mem.rs2_data;
        end
    end

    // Writeback select, also the forward value
    assign wb_data = ex_mem.dren ? load_data : ex_mem.alu_out;
    assign rf_wen  = slot_live && ex_mem.reg_write;
    assign rf_rd   = ex_mem.rd;

    // Retire port
    assign retire_valid = slot_live;
    assign retire_pc    = ex_mem.pc;
    assign illegal      = slot_live && ex_mem.illegal;

    // Sticky once ECALL retires
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            halted <= 1'b0;
        end else if (slot_live && ex_mem.halt) begin
            halted <= 1'b1;
        end
    end

endmodule

//--- src/hazard_unit.sv
`timescale 1ns/1ns

module hazard_unit (
    input  logic              [4:0] rs1_addr,
    input  logic              [4:0] rs2_addr,
    input  core_pkg::ex_mem_t ex_mem,
    input  logic              redirect,
    output logic              fwd_rs1,
    output logic              fwd_rs2,
    output logic              flush
);

    logic mem_writes;

    // Memory stage holds a result bound for a real register
    assign mem_writes = ex_mem.reg_write && (ex_mem.rd != 5'd0);

    // Older results already sit in the register file
    // so only the memory stage needs a compare
    assign fwd_rs1 = mem_writes && (ex_mem.rd == rs1_addr);
    assign fwd_rs2 = mem_writes && (ex_mem.rd == rs2_addr);

    // Taken branch or jump kills the one younger fetch
    // The redirecting instruction itself still proceeds
    assign flush = redirect;

endmodule

//--- src/core_top.sv
`timescale 1ns/1ns

module core_top (
    input  logic            CLK,
    input  logic            nRST,
    output logic            imem_req,
    output core_pkg::word_t imem_addr,
    input  core_pkg::word_t imem_rdata,
    output logic            retire_valid,
    output core_pkg::word_t retire_pc,
    output logic            rf_wen,
    output logic [4:0]      rf_rd,
    output core_pkg::word_t wb_data,
    output logic            halted,
    output logic            illegal
);
    import core_pkg::*;

    fetch_ex_t  fetch_ex;
    ex_mem_t    ex_mem;
    logic [4:0] rs1_addr;
    logic [4:0] rs2_addr;
    word_t      rs1_data;
    word_t      rs2_data;
    logic       fwd_rs1;
    logic       fwd_rs2;
    logic       redirect;
    word_t      redirect_pc;
    logic       flush;

    // Flush squashes fetch, halted stops it
    fetch_stage u_fetch (
        .CLK, .nRST,
        .redirect(flush), .redirect_pc, .halt_seen(halted),
        .imem_rdata, .imem_req, .imem_addr, .fetch_ex
    );

    // wb_data doubles as the forward value
    execute_stage u_execute (
        .CLK, .nRST, .fetch_ex,
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .fwd_rs1, .fwd_rs2, .fwd_data(wb_data),
        .redirect, .redirect_pc, .ex_mem
    );

    reg_file u_reg_file (
        .CLK, .nRST, .rs1_addr, .rs2_addr,
        .rd(rf_rd), .wen(rf_wen), .wdata(wb_data),
        .rs1_data, .rs2_data
    );

    mem_stage u_mem (
        .CLK, .nRST, .ex_mem,
        .rf_wen, .rf_rd, .wb_data,
        .retire_valid, .retire_pc, .halted, .illegal
    );

    hazard_unit u_hazard (
        .rs1_addr, .rs2_addr, .ex_mem, .redirect,
        .fwd_rs1, .fwd_rs2, .flush
    );

endmodule

//--- dv/core_tb.sv
`timescale 1ns/1ns
`include "core_cfg.svh"

module core_tb;
    import core_pkg::*;

    localparam int T_IMM  = 0;
    localparam int T_ALU  = 1;
    localparam int T_FWD  = 2;
    localparam int T_MEM  = 3;
    localparam int T_CTRL = 4;
    localparam int T_END  = 5;
    localparam int RESET_CYCLES = 8;

    // Starts low so time zero carries no clock edge
    logic       CLK = 1'b0;
    logic       nRST;
    logic       imem_req;
    word_t      imem_addr;
    word_t      imem_rdata;
    logic       retire_valid;
    word_t      retire_pc;
    logic       rf_wen;
    logic [4:0] rf_rd;
    word_t      wb_data;
    logic       halted;
    logic       illegal;

    // Program ROM and the test tag of each word
    word_t prog [0:63];
    int    prog_test [0:63];
    int    np;
    // Expected retirements from the reference model
    word_t      exp_pc [0:63];
    logic       exp_wen [0:63];
    logic [4:0] exp_rd [0:63];
    word_t      exp_val [0:63];
    logic       exp_ill [0:63];
    int         exp_test [0:63];
    int         n_exp;
    // Architectural state of the model
    word_t mdl_reg [0:31];
    word_t mdl_mem [0:`CORE_DMEM_WORDS-1];
    string test_name [0:5];
    int    test_err [0:5];
    int    ridx;
    int    cur_test;
    int    errors;
    int    cycles;
    int    limit;
    word_t rng;
    logic  req_q;
    word_t addr_q;

    core_top uut (
        .CLK, .nRST, .imem_req, .imem_addr, .imem_rdata,
        .retire_valid, .retire_pc, .rf_wen, .rf_rd, .wb_data, .halted, .illegal
    );

    initial begin
        forever #20 CLK = ~CLK;
    end

    function automatic word_t xorshift(input word_t s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // RV32I encoders
    function automatic word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                    input logic [4:0] rs1, input logic [2:0] f3,
                                    input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                    input logic [2:0] f3, input logic [4:0] rd,
                                    input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                    input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic word_t enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                    input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic word_t enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
    endfunction

    task automatic emit(input word_t ins, input int t);
        prog[np]      = ins;
        prog_test[np] = t;
        np++;
    endtask

    task automatic build_program;
        for (int i = 0; i < 64; i++) begin
            prog[i]      = '0;
            prog_test[i] = T_END;
        end
        np = 0;
        // Random constants in x1 and x2, then an x0 write and a read of x0
        for (int r = 1; r <= 2; r++) begin
            rng = xorshift(rng);
            emit({rng[31:12], 5'(r), 7'h37}, T_IMM);
            rng = xorshift(rng);
            emit(enc_i(rng[11:0], 5'(r), 3'b000, 5'(r), 7'h13), T_IMM);
        end
        rng = xorshift(rng);
        emit(enc_i(rng[11:0], 5'd0, 3'b000, 5'd0, 7'h13), T_IMM);
        emit(enc_r(7'h00, 5'd1, 5'd0, 3'b000, 5'd10), T_IMM);
        // Reg-reg ALU ops
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), T_ALU);
        emit(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd4), T_ALU);
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd5), T_ALU);
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd6), T_ALU);
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd7), T_ALU);
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd8), T_ALU);
        emit(enc_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd9), T_ALU);
        // Dependent chain with a load followed at once by its consumer
        emit(enc_r(7'h00, 5'd4, 5'd3, 3'b000, 5'd11), T_FWD);
        emit(enc_r(7'h20, 5'd1, 5'd11, 3'b000, 5'd12), T_FWD);
        emit(enc_i(12'd7, 5'd12, 3'b000, 5'd13, 7'h13), T_FWD);
        emit(enc_s(12'd16, 5'd13, 5'd0), T_FWD);
        emit(enc_i(12'd16, 5'd0, 3'b010, 5'd14, 7'h03), T_FWD);
        emit(enc_r(7'h00, 5'd14, 5'd14, 3'b000, 5'd15), T_FWD);
        // Stores and loads to the same and to different words, then an overwrite
        emit(enc_i(12'd64, 5'd0, 3'b000, 5'd16, 7'h13), T_MEM);
        emit(enc_s(12'd0, 5'd1, 5'd16), T_MEM);
        emit(enc_s(12'd4, 5'd2, 5'd16), T_MEM);
        emit(enc_i(12'd0, 5'd16, 3'b010, 5'd17, 7'h03), T_MEM);
        emit(enc_i(12'd4, 5'd16, 3'b010, 5'd18, 7'h03), T_MEM);
        emit(enc_i(12'd16, 5'd0, 3'b010, 5'd19, 7'h03), T_MEM);
        emit(enc_s(12'd0, 5'd3, 5'd16), T_MEM);
        emit(enc_i(12'd0, 5'd16, 3'b010, 5'd20, 7'h03), T_MEM);
        // Taken BEQ, not-taken BNE, taken BNE, JAL, not-taken BEQ
        emit(enc_b(13'd8, 5'd1, 5'd1, 3'b000), T_CTRL);
        emit(enc_i(12'd1, 5'd0, 3'b000, 5'd21, 7'h13), T_CTRL);
        emit(enc_b(13'd8, 5'd1, 5'd1, 3'b001), T_CTRL);
        emit(enc_b(13'd8, 5'd2, 5'd1, 3'b001), T_CTRL);
        emit(enc_i(12'd2, 5'd0, 3'b000, 5'd21, 7'h13), T_CTRL);
        emit(enc_j(21'd8, 5'd22), T_CTRL);
        emit(enc_i(12'd3, 5'd0, 3'b000, 5'd21, 7'h13), T_CTRL);
        emit(enc_b(13'd8, 5'd2, 5'd1, 3'b000), T_CTRL);
        emit(enc_i(12'd1, 5'd22, 3'b000, 5'd23, 7'h13), T_CTRL);
        // Undefined encoding, one more op, then ECALL and a tail that must not retire
        emit(32'hffff_ffff, T_END);
        emit(enc_i(12'd5, 5'd23, 3'b000, 5'd24, 7'h13), T_END);
        emit(32'h0000_0073, T_END);
        emit(enc_i(12'd9, 5'd0, 3'b000, 5'd25, 7'h13), T_END);
    endtask

    // Architectural model of the RV32I subset
    task automatic run_model;
        word_t pc;
        word_t ins;
        word_t a;
        word_t b;
        word_t res;
        word_t nxt;
        word_t imm_i;
        word_t imm_s;
        word_t imm_b;
        word_t imm_j;
        logic  wen;
        logic  ill;
        logic  done;
        logic [2:0] f3;
        pc    = `CORE_RESET_PC;
        done  = 1'b0;
        n_exp = 0;
        for (int i = 0; i < 32; i++) begin
            mdl_reg[i] = '0;
        end
        while (!done && n_exp < 64) begin
            ins   = prog[pc[7:2]];
            f3    = ins[14:12];
            a     = mdl_reg[ins[19:15]];
            b     = mdl_reg[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            wen   = 1'b0;
            ill   = 1'b0;
            res   = '0;
            nxt   = pc + 32'd4;
            case (ins[6:0])
                7'h33: begin
                    wen = 1'b1;
                    case ({ins[31:25], f3})
                        10'h000: res = a + b;
                        10'h100: res = a - b;
                        10'h007: res = a & b;
                        10'h006: res = a | b;
                        10'h004: res = a ^ b;
                        10'h002: res = {31'b0, $signed(a) < $signed(b)};
                        default: begin
                            wen = 1'b0;
                            ill = 1'b1;
                        end
                    endcase
                end
                7'h13: begin
                    wen = (f3 == 3'b000);
                    ill = !wen;
                    res = a + imm_i;
                end
                7'h37: begin
                    wen = 1'b1;
                    res = {ins[31:12], 12'b0};
                end
                7'h03: begin
                    wen = (f3 == 3'b010);
                    ill = !wen;
                    res = mdl_mem[((a + imm_i) >> 2) % `CORE_DMEM_WORDS];
                end
                7'h23: begin
                    ill = (f3 != 3'b010);
                    if (!ill) mdl_mem[((a + imm_s) >> 2) % `CORE_DMEM_WORDS] = b;
                end
                7'h63: begin
                    ill = (f3[2:1] != 2'b00);
                    // BEQ on f3 0, BNE on f3 1
                    if (!ill && ((a == b) != f3[0])) nxt = pc + imm_b;
                end
                7'h6f: begin
                    wen = 1'b1;
                    res = pc + 32'd4;
                    nxt = pc + imm_j;
                end
                7'h73: begin
                    done = (ins == 32'h0000_0073);
                    ill  = !done;
                end
                default: ill = 1'b1;
            endcase
            if (wen && ins[11:7] != 5'd0) mdl_reg[ins[11:7]] = res;
            exp_pc[n_exp]   = pc;
            exp_wen[n_exp]  = wen;
            exp_rd[n_exp]   = ins[11:7];
            exp_val[n_exp]  = res;
            exp_ill[n_exp]  = ill;
            exp_test[n_exp] = prog_test[pc[7:2]];
            n_exp++;
            pc = nxt;
        end
    endtask

    task automatic check_word(input string name, input word_t act, input word_t exp);
        assert (act === exp) else begin
            $display("[FAIL] t=%0t %s: expected %h, actual %h", $time, name, exp, act);
            errors++;
            test_err[cur_test]++;
        end
    endtask

    // Instruction ROM answers the request taken at the previous edge
    always @(posedge CLK) begin
        #2;
        imem_rdata = req_q ? prog[addr_q[7:2]] : '0;
        req_q      = imem_req;
        addr_q     = imem_addr;
    end

    // Retirement checks where the mem stage outputs are settled
    always @(negedge CLK) begin
        if (!nRST) begin
            assert (!retire_valid && !halted && !illegal) else begin
                $display("t=%0t retire, halted or illegal active during reset", $time);
                errors++;
            end
        end else begin
            if (halted) begin
                assert (!imem_req) else begin
                    $display("t=%0t fetch still requesting after halt", $time);
                    errors++;
                end
            end
            if (retire_valid) begin
                assert (ridx < n_exp) else begin
                    $display("t=%0t unexpected retirement at pc %h", $time, retire_pc);
                    errors++;
                end
                if (ridx < n_exp) begin
                    cur_test = exp_test[ridx];
                    check_word("retire_pc", retire_pc, exp_pc[ridx]);
                    check_word("rf_wen", 32'(rf_wen), 32'(exp_wen[ridx]));
                    check_word("illegal", 32'(illegal), 32'(exp_ill[ridx]));
                    if (exp_wen[ridx] && exp_rd[ridx] != 5'd0) begin
                        check_word("rf_rd", 32'(rf_rd), 32'(exp_rd[ridx]));
                        check_word("wb_data", wb_data, exp_val[ridx]);
                    end
                    // Last retirement of a test
                    if (ridx == n_exp - 1 || exp_test[ridx + 1] != cur_test) begin
                        $display("test %s: %0d errors", test_name[cur_test],
                                 test_err[cur_test]);
                    end
                    ridx++;
                end
            end
        end
    end

    // Cycle budget
    always @(posedge CLK) begin
        cycles++;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: program did not halt");
            $display("retired %0d of %0d, errors %0d", ridx, n_exp, errors);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        nRST       = 1'b0;
        imem_rdata = '0;
        req_q      = 1'b0;
        addr_q     = '0;
        ridx       = 0;
        cur_test   = 0;
        errors     = 0;
        cycles     = 0;
        limit      = 0;
        rng        = 32'd22;
        test_name  = '{"imm", "alu", "fwd", "mem", "ctrl", "end"};
        for (int t = 0; t < 6; t++) begin
            test_err[t] = 0;
        end
        build_program();
        run_model();
        limit = 4 * n_exp + RESET_CYCLES + 50;
        repeat (RESET_CYCLES) @(posedge CLK);
        #2;
        nRST = 1'b1;
        while (!(halted && ridx == n_exp)) @(posedge CLK);
        // Tail must not retire
        repeat (8) @(posedge CLK);
        $display("tests 6, retired %0d of %0d, errors %0d", ridx, n_exp, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+src
src/core_pkg.sv
src/fetch_stage.sv
src/execute_stage.sv
src/reg_file.sv
src/mem_stage.sv
src/hazard_unit.sv
src/core_top.sv
dv/core_tb.sv

//--- Bender.yml
package:
  name: rv32i_core

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/core_pkg.sv
      - src/fetch_stage.sv
      - src/execute_stage.sv
      - src/reg_file.sv
      - src/mem_stage.sv
      - src/hazard_unit.sv
      - src/core_top.sv

  - target: test
    include_dirs:
      - src
    files:
      - dv/core_tb.sv
